// File: dv/tb_clkgen.sv
// Testbench clock and reset source, 10 ns clk_sys with reset held low for the first cycles
module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);

timeunit 1ns;
timeprecision 1ps;

localparam int HALF_PERIOD  = 5;
localparam int RESET_CYCLES = 5;

initial begin
	o_clk = 1'b0;
	forever #HALF_PERIOD o_clk = ~o_clk;
end

initial begin
	o_rst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge o_clk);
	@(negedge o_clk);
	o_rst_n = 1'b1;       // Released on a falling edge, away from the sampling edge
end

endmodule

// File: dv/tb_riscboy_periph.sv
// Table-driven testbench for the peripheral subsystem, run as the simulation top
module tb_riscboy_periph;

timeunit 1ns;
timeprecision 1ps;

localparam int unsigned SEED          = 32'h2437_0d73;
localparam int          N_GPIO        = 8;
localparam int          N_PADIN       = 6;
localparam int          RESET_TIMEOUT = 20;
localparam int          LEVEL_TIMEOUT = 4;   // Output is registered, one cycle is enough

typedef struct packed {
	logic                      to_oe;        // 1 writes GPIO_OE, 0 writes GPIO_OUT
	riscboy_periph_pkg::word_t wdata;
	riscboy_periph_pkg::pad_t  exp;
} gpio_entry_t;

typedef struct packed {
	riscboy_periph_pkg::pwm_t div;
	riscboy_periph_pkg::pwm_t cmp;
	logic                     inv;
	int                       exp_high;     // High cycles over one full period
} pwm_entry_t;

typedef struct packed {
	riscboy_periph_pkg::paddr_t addr;
	logic                       write;
} err_entry_t;

logic                         clk;
logic                         rst_n;
riscboy_periph_pkg::apb_req_t apb_req;
riscboy_periph_pkg::apb_rsp_t apb_rsp;
riscboy_periph_pkg::pad_t     padout;
riscboy_periph_pkg::pad_t     padoe;
riscboy_periph_pkg::pad_t     padin;
logic                         lcd_pwm;

gpio_entry_t                  gpio_tab [$];
riscboy_periph_pkg::pad_t     padin_tab [$];
err_entry_t                   err_tab [$];
pwm_entry_t                   pwm_tab [$];
riscboy_periph_pkg::pad_t     exp_out;       // Shadow of the pad registers
riscboy_periph_pkg::pad_t     exp_oe;
int                           n_fail    = 0;
int                           n_timeout = 0;

tb_clkgen u_clkgen (
	.o_clk   (clk),
	.o_rst_n (rst_n)
);

riscboy_periph dut0 (
	.i_clk_sys (clk),
	.i_rst_n   (rst_n),
	.i_apb     (apb_req),
	.o_apb     (apb_rsp),
	.o_padout  (padout),
	.o_padoe   (padoe),
	.i_padin   (padin),
	.o_lcd_pwm (lcd_pwm)
);

// ==============================
// Address helpers
// ==============================

function automatic riscboy_periph_pkg::paddr_t gpio_addr(input riscboy_periph_pkg::gpio_reg_e r);
	return {riscboy_periph_pkg::REGION_GPIO, r};
endfunction

function automatic riscboy_periph_pkg::paddr_t pwm_addr(input riscboy_periph_pkg::pwm_reg_e r);
	return {riscboy_periph_pkg::REGION_PWM, r};
endfunction

// ==============================
// Compare tasks
// ==============================

task automatic check_word(input riscboy_periph_pkg::word_t got,
		input riscboy_periph_pkg::word_t exp, input string what);
	if (got !== exp) begin
		n_fail++;
		$display("FAILED at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
	end
endtask

task automatic check_err(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		n_fail++;
		$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_pads(input riscboy_periph_pkg::pad_t got,
		input riscboy_periph_pkg::pad_t exp, input string what);
	if (got !== exp) begin
		n_fail++;
		$display("FAILED at %0t ns: %s is 0x%03h, expected 0x%03h", $time, what, got, exp);
	end
endtask

task automatic check_count(input int got, input int exp, input string what);
	if (got != exp) begin
		n_fail++;
		$display("FAILED at %0t ns: %s counted %0d, expected %0d", $time, what, got, exp);
	end
endtask

// ==============================
// APB and wait tasks
// ==============================

// Setup cycle, access cycle, then idle once the access edge has passed
task automatic apb_access(input riscboy_periph_pkg::paddr_t addr, input logic write,
		input riscboy_periph_pkg::word_t wdata, output riscboy_periph_pkg::word_t rdata,
		output logic err);
	@(negedge clk);
	apb_req.paddr   = addr;
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = write;
	apb_req.pwdata  = wdata;
	@(negedge clk);
	apb_req.penable = 1'b1;
	#1;                                 // Response settles well before the access edge
	rdata = apb_rsp.prdata;
	err   = apb_rsp.pslverr;
	@(negedge clk);
	apb_req.psel    = 1'b0;
	apb_req.penable = 1'b0;
endtask

task automatic apb_write(input riscboy_periph_pkg::paddr_t addr,
		input riscboy_periph_pkg::word_t wdata, output logic err);
	riscboy_periph_pkg::word_t unused;
	apb_access(addr, 1'b1, wdata, unused, err);
endtask

task automatic apb_read(input riscboy_periph_pkg::paddr_t addr,
		output riscboy_periph_pkg::word_t rdata, output logic err);
	apb_access(addr, 1'b0, '0, rdata, err);
endtask

task automatic wait_cycles(input int n);
	for (int i = 0; i < n; i++)
		@(negedge clk);
endtask

task automatic wait_reset_release();
	int n;
	n = 0;
	while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	if (rst_n !== 1'b1) begin
		n_timeout++;
		$display("Timeout: reset was still asserted after %0d cycles", RESET_TIMEOUT);
	end
endtask

task automatic wait_pwm_level(input logic level);
	int n;
	n = 0;
	while (lcd_pwm !== level && n < LEVEL_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	if (lcd_pwm !== level) begin
		n_timeout++;
		$display("Timeout: the backlight output did not settle to %b after disable", level);
	end
endtask

task automatic count_high(input int window, output int n);
	n = 0;
	for (int i = 0; i < window; i++) begin
		@(negedge clk);
		if (lcd_pwm === 1'b1)
			n++;
	end
endtask

// ==============================
// Tables
// ==============================

task automatic add_pwm(input riscboy_periph_pkg::pwm_t div, input riscboy_periph_pkg::pwm_t cmp,
		input logic inv, input int exp_high);
	pwm_entry_t e;
	e.div      = div;
	e.cmp      = cmp;
	e.inv      = inv;
	e.exp_high = exp_high;
	pwm_tab.push_back(e);
endtask

task automatic add_err(input riscboy_periph_pkg::paddr_t addr, input logic write);
	err_entry_t e;
	e.addr  = addr;
	e.write = write;
	err_tab.push_back(e);
endtask

task automatic build_tables();
	gpio_entry_t g;
	for (int i = 0; i < N_GPIO; i++) begin
		g.to_oe = $urandom_range(1, 0);
		g.wdata = $urandom();
		g.exp   = g.wdata[riscboy_periph_pkg::N_PADS-1:0];   // Upper bits are dropped
		gpio_tab.push_back(g);
	end
	for (int i = 0; i < N_PADIN; i++)
		padin_tab.push_back(riscboy_periph_pkg::pad_t'($urandom()));
	// Unmapped regions at live block offsets, alternating reads and writes
	for (int r = 2; r < 16; r++)
		add_err(riscboy_periph_pkg::paddr_t'(r * 32'h1000 + (r % 3) * 4), (r % 2) == 1);
	add_err(16'h000C, 1'b1);
	add_err(16'h0002, 1'b0);
	add_err(16'h0FFC, 1'b1);
	add_err(16'h100C, 1'b1);
	add_err(16'h1006, 1'b1);
	add_err(16'h1800, 1'b0);
	add_err(gpio_addr(riscboy_periph_pkg::GPIO_IN), 1'b1);
	// div, cmp, invert, high cycles per period
	add_pwm(8'd0, 8'd0,   1'b0, 0);
	add_pwm(8'd0, 8'd128, 1'b0, 128);
	add_pwm(8'd1, 8'd64,  1'b0, 128);
	add_pwm(8'd2, 8'd200, 1'b1, 168);
	add_pwm(8'd3, 8'd255, 1'b0, 1020);
	add_pwm(8'd0, 8'd1,   1'b1, 255);
	add_pwm(8'd4, 8'd100, 1'b1, 780);
endtask

// ==============================
// Test stages
// ==============================

task automatic check_reset_state();
	riscboy_periph_pkg::paddr_t regs [6];
	riscboy_periph_pkg::word_t  rdata;
	logic                       err;
	regs[0] = gpio_addr(riscboy_periph_pkg::GPIO_OUT);
	regs[1] = gpio_addr(riscboy_periph_pkg::GPIO_OE);
	regs[2] = gpio_addr(riscboy_periph_pkg::GPIO_IN);
	regs[3] = pwm_addr(riscboy_periph_pkg::PWM_CTRL);
	regs[4] = pwm_addr(riscboy_periph_pkg::PWM_DIV);
	regs[5] = pwm_addr(riscboy_periph_pkg::PWM_CMP);
	check_pads(padout, '0, "o_padout after reset");
	check_pads(padoe, '0, "o_padoe after reset");
	check_err(lcd_pwm, 1'b0, "o_lcd_pwm after reset");
	foreach (regs[i]) begin
		apb_read(regs[i], rdata, err);
		check_word(rdata, '0, $sformatf("reset value at 0x%04h", regs[i]));
		check_err(err, 1'b0, $sformatf("pslverr at 0x%04h", regs[i]));
	end
endtask

task automatic run_gpio_table();
	riscboy_periph_pkg::paddr_t addr;
	riscboy_periph_pkg::word_t  rdata;
	logic                       err;
	foreach (gpio_tab[i]) begin
		addr = gpio_tab[i].to_oe ? gpio_addr(riscboy_periph_pkg::GPIO_OE)
			: gpio_addr(riscboy_periph_pkg::GPIO_OUT);
		apb_write(addr, gpio_tab[i].wdata, err);
		check_err(err, 1'b0, $sformatf("GPIO entry %0d write pslverr", i));
		if (gpio_tab[i].to_oe)
			exp_oe = gpio_tab[i].exp;
		else
			exp_out = gpio_tab[i].exp;
		check_pads(padout, exp_out, $sformatf("GPIO entry %0d o_padout", i));
		check_pads(padoe, exp_oe, $sformatf("GPIO entry %0d o_padoe", i));
		apb_read(addr, rdata, err);
		check_word(rdata, riscboy_periph_pkg::word_t'(gpio_tab[i].exp),
			$sformatf("GPIO entry %0d readback", i));
		check_err(err, 1'b0, $sformatf("GPIO entry %0d read pslverr", i));
	end
endtask

task automatic run_padin_table();
	riscboy_periph_pkg::word_t rdata;
	logic                      err;
	foreach (padin_tab[i]) begin
		@(negedge clk);
		padin = padin_tab[i];
		wait_cycles(3);                  // Two synchronizer stages plus margin
		apb_read(gpio_addr(riscboy_periph_pkg::GPIO_IN), rdata, err);
		check_word(rdata, riscboy_periph_pkg::word_t'(padin_tab[i]),
			$sformatf("GPIO_IN entry %0d", i));
		check_err(err, 1'b0, $sformatf("GPIO_IN entry %0d pslverr", i));
	end
endtask

task automatic run_error_table();
	riscboy_periph_pkg::word_t rdata;
	logic                      err;
	foreach (err_tab[i]) begin
		apb_access(err_tab[i].addr, err_tab[i].write, 32'hFFFF_FFFF, rdata, err);
		check_err(err, 1'b1, $sformatf("pslverr at 0x%04h", err_tab[i].addr));
		check_word(rdata, '0, $sformatf("error read data at 0x%04h", err_tab[i].addr));
		check_pads(padout, exp_out, $sformatf("o_padout after 0x%04h", err_tab[i].addr));
		check_pads(padoe, exp_oe, $sformatf("o_padoe after 0x%04h", err_tab[i].addr));
	end
	// Registers must have kept their values
	apb_read(gpio_addr(riscboy_periph_pkg::GPIO_OUT), rdata, err);
	check_word(rdata, riscboy_periph_pkg::word_t'(exp_out), "GPIO_OUT after errors");
	apb_read(gpio_addr(riscboy_periph_pkg::GPIO_OE), rdata, err);
	check_word(rdata, riscboy_periph_pkg::word_t'(exp_oe), "GPIO_OE after errors");
	apb_read(gpio_addr(riscboy_periph_pkg::GPIO_IN), rdata, err);
	check_word(rdata, riscboy_periph_pkg::word_t'(padin), "GPIO_IN after errors");
	apb_read(pwm_addr(riscboy_periph_pkg::PWM_CTRL), rdata, err);
	check_word(rdata, '0, "PWM_CTRL after errors");
	apb_read(pwm_addr(riscboy_periph_pkg::PWM_DIV), rdata, err);
	check_word(rdata, '0, "PWM_DIV after errors");
	apb_read(pwm_addr(riscboy_periph_pkg::PWM_CMP), rdata, err);
	check_word(rdata, '0, "PWM_CMP after errors");
	check_err(lcd_pwm, 1'b0, "o_lcd_pwm after errors");
endtask

task automatic run_pwm_table();
	riscboy_periph_pkg::word_t rdata;
	logic                      err;
	int                        period;
	int                        n_high;
	foreach (pwm_tab[i]) begin
		period = 256 * (int'(pwm_tab[i].div) + 1);
		apb_write(pwm_addr(riscboy_periph_pkg::PWM_DIV), 32'(pwm_tab[i].div), err);
		check_err(err, 1'b0, $sformatf("PWM entry %0d DIV write", i));
		apb_write(pwm_addr(riscboy_periph_pkg::PWM_CMP), 32'(pwm_tab[i].cmp), err);
		check_err(err, 1'b0, $sformatf("PWM entry %0d CMP write", i));
		apb_write(pwm_addr(riscboy_periph_pkg::PWM_CTRL), {30'd0, pwm_tab[i].inv, 1'b1}, err);
		check_err(err, 1'b0, $sformatf("PWM entry %0d CTRL write", i));
		apb_read(pwm_addr(riscboy_periph_pkg::PWM_CMP), rdata, err);
		check_word(rdata, 32'(pwm_tab[i].cmp), $sformatf("PWM entry %0d CMP readback", i));
		apb_read(pwm_addr(riscboy_periph_pkg::PWM_DIV), rdata, err);
		check_word(rdata, 32'(pwm_tab[i].div), $sformatf("PWM entry %0d DIV readback", i));
		apb_read(pwm_addr(riscboy_periph_pkg::PWM_CTRL), rdata, err);
		check_word(rdata, {30'd0, pwm_tab[i].inv, 1'b1},
			$sformatf("PWM entry %0d CTRL readback", i));
		wait_cycles(period);             // Let the divider and counter settle
		count_high(period, n_high);
		check_count(n_high, pwm_tab[i].exp_high, $sformatf("PWM entry %0d high cycles", i));
		// Disabled output rests at the invert level
		apb_write(pwm_addr(riscboy_periph_pkg::PWM_CTRL), {30'd0, pwm_tab[i].inv, 1'b0}, err);
		wait_pwm_level(pwm_tab[i].inv);
		if (n_timeout != 0)
			break;
		count_high(256, n_high);
		check_count(n_high, pwm_tab[i].inv ? 256 : 0, $sformatf("PWM entry %0d disabled", i));
	end
endtask

// ==============================
// Main sequence
// ==============================

initial begin
	apb_req = '0;
	padin   = '0;
	exp_out = '0;
	exp_oe  = '0;
	void'($urandom(SEED));
	build_tables();
	wait_reset_release();
	if (n_timeout == 0)
		check_reset_state();
	if (n_timeout == 0)
		run_gpio_table();
	if (n_timeout == 0)
		run_padin_table();
	if (n_timeout == 0)
		run_error_table();
	if (n_timeout == 0)
		run_pwm_table();
	$display("Summary: %0d check errors, %0d timeouts", n_fail, n_timeout);
	if (n_fail == 0 && n_timeout == 0)
		$display("Test passed");
	else
		$display("Test failed");
	$finish;
end

endmodule

// File: src/apb_splitter.sv
// APB splitter: decodes the region, forwards the request to one slot and muxes its response back
module apb_splitter (
	input  logic                         i_clk_sys,   // Assertions only
	input  logic                         i_rst_n,     // Assertions only

	input  riscboy_periph_pkg::apb_req_t i_apb,
	output riscboy_periph_pkg::apb_rsp_t o_apb,

	output riscboy_periph_pkg::apb_req_t o_gpio_req,
	input  riscboy_periph_pkg::apb_rsp_t i_gpio_rsp,
	output riscboy_periph_pkg::apb_req_t o_pwm_req,
	input  riscboy_periph_pkg::apb_rsp_t i_pwm_rsp
);

riscboy_periph_pkg::apb_slot_e           slot;
logic [riscboy_periph_pkg::W_REGION-1:0] region;

// ==============================
// Address decode
// ==============================

assign region = i_apb.paddr[riscboy_periph_pkg::W_PADDR-1 -: riscboy_periph_pkg::W_REGION];

always_comb begin
	case (region)
		riscboy_periph_pkg::REGION_GPIO: slot = riscboy_periph_pkg::SLOT_GPIO;
		riscboy_periph_pkg::REGION_PWM:  slot = riscboy_periph_pkg::SLOT_PWM;
		default:                         slot = riscboy_periph_pkg::SLOT_NONE;
	endcase
end

// ==============================
// Request fan-out
// ==============================

// Copy of the request for one slot, offset only, strobes gated by the hit
function automatic riscboy_periph_pkg::apb_req_t slot_req(
	input riscboy_periph_pkg::apb_req_t req,
	input logic                         hit
);
	riscboy_periph_pkg::apb_req_t r;
	r = req;
	r.paddr = {
		{riscboy_periph_pkg::W_REGION{1'b0}},
		req.paddr[riscboy_periph_pkg::W_OFFSET-1:0]
	};
	r.psel    = req.psel && hit;
	r.penable = req.penable && hit;  // Keeps penable low on the unselected slot
	return r;
endfunction

assign o_gpio_req = slot_req(i_apb, slot == riscboy_periph_pkg::SLOT_GPIO);
assign o_pwm_req  = slot_req(i_apb, slot == riscboy_periph_pkg::SLOT_PWM);

// ==============================
// Response mux
// ==============================

always_comb begin
	case (slot)
		riscboy_periph_pkg::SLOT_GPIO: o_apb = i_gpio_rsp;
		riscboy_periph_pkg::SLOT_PWM:  o_apb = i_pwm_rsp;
		default: begin
			o_apb.prdata  = '0;    // Unmapped region
			o_apb.pslverr = 1'b1;
		end
	endcase
end

// ==============================
// Protocol checks
// ==============================

a_penable_needs_psel: assert property (
	@(posedge i_clk_sys) disable iff (!i_rst_n)
	i_apb.penable |-> i_apb.psel
);

// Every setup cycle is followed by an access cycle carrying the same request
a_setup_then_access: assert property (
	@(posedge i_clk_sys) disable iff (!i_rst_n)
	i_apb.psel && !i_apb.penable |=>
		i_apb.psel && i_apb.penable
		&& $stable(i_apb.paddr)
		&& $stable(i_apb.pwrite)
		&& $stable(i_apb.pwdata)
);

endmodule

// File: src/gpio.sv
// GPIO block on APB: output and output-enable registers plus a synchronized pad input register
module gpio (
	input  logic                         i_clk_sys,
	input  logic                         i_rst_n,

	input  riscboy_periph_pkg::apb_req_t i_apb,
	output riscboy_periph_pkg::apb_rsp_t o_apb,

	output riscboy_periph_pkg::pad_t     o_padout,
	output riscboy_periph_pkg::pad_t     o_padoe,
	input  riscboy_periph_pkg::pad_t     i_padin
);

riscboy_periph_pkg::pad_t      padout_q;
riscboy_periph_pkg::pad_t      padoe_q;
riscboy_periph_pkg::pad_t      padin_meta;  // First synchronizer stage
riscboy_periph_pkg::pad_t      padin_sync;
riscboy_periph_pkg::gpio_reg_e reg_sel;
riscboy_periph_pkg::word_t     rdata;
logic                          err;
logic                          wr_en;

assign reg_sel = riscboy_periph_pkg::gpio_reg_e'(i_apb.paddr[riscboy_periph_pkg::W_OFFSET-1:0]);

// ==============================
// Register decode
// ==============================

always_comb begin
	rdata = '0;
	err   = 1'b0;
	case (reg_sel)
		riscboy_periph_pkg::GPIO_OUT: rdata = riscboy_periph_pkg::word_t'(padout_q);
		riscboy_periph_pkg::GPIO_OE:  rdata = riscboy_periph_pkg::word_t'(padoe_q);
		riscboy_periph_pkg::GPIO_IN: begin
			if (i_apb.pwrite)
				err = 1'b1;                  // Read only
			else
				rdata = riscboy_periph_pkg::word_t'(padin_sync);
		end
		default: err = 1'b1;                 // Unknown offset
	endcase
end

assign o_apb.prdata  = rdata;
assign o_apb.pslverr = i_apb.psel && err;

// Write lands at the edge closing the access phase
assign wr_en = i_apb.psel && i_apb.penable && i_apb.pwrite && !err;

// ==============================
// Registers
// ==============================

always_ff @(posedge i_clk_sys or negedge i_rst_n) begin
	if (!i_rst_n) begin
		padout_q <= '0;
		padoe_q  <= '0;
	end else if (wr_en) begin
		case (reg_sel)
			riscboy_periph_pkg::GPIO_OUT: padout_q <= i_apb.pwdata[riscboy_periph_pkg::N_PADS-1:0];
			riscboy_periph_pkg::GPIO_OE:  padoe_q  <= i_apb.pwdata[riscboy_periph_pkg::N_PADS-1:0];
			default: ;
		endcase
	end
end

// Pads are asynchronous to clk_sys
always_ff @(posedge i_clk_sys or negedge i_rst_n) begin
	if (!i_rst_n) begin
		padin_meta <= '0;
		padin_sync <= '0;
	end else begin
		padin_meta <= i_padin;
		padin_sync <= padin_meta;
	end
end

assign o_padout = padout_q;
assign o_padoe  = padoe_q;

// The splitter must gate penable along with psel for this slot
a_penable_needs_psel: assert property (
	@(posedge i_clk_sys) disable iff (!i_rst_n)
	i_apb.penable |-> i_apb.psel
);

endmodule

// File: src/pwm_tiny.sv
// Backlight PWM on APB: control, divider and compare registers driving a registered duty output
module pwm_tiny (
	input  logic                         i_clk_sys,
	input  logic                         i_rst_n,

	input  riscboy_periph_pkg::apb_req_t i_apb,
	output riscboy_periph_pkg::apb_rsp_t o_apb,

	output logic                         o_lcd_pwm
);

logic [riscboy_periph_pkg::W_PWM_CTRL-1:0] ctrl_q;
riscboy_periph_pkg::pwm_t                  div_q;
riscboy_periph_pkg::pwm_t                  cmp_q;
riscboy_periph_pkg::pwm_t                  div_ctr;
riscboy_periph_pkg::pwm_t                  ctr;
riscboy_periph_pkg::pwm_reg_e              reg_sel;
riscboy_periph_pkg::word_t                 rdata;
logic                                      err;
logic                                      wr_en;
logic                                      tick;
logic                                      en;
logic                                      inv;
logic                                      pwm_q;

assign reg_sel = riscboy_periph_pkg::pwm_reg_e'(i_apb.paddr[riscboy_periph_pkg::W_OFFSET-1:0]);
assign en      = ctrl_q[riscboy_periph_pkg::PWM_CTRL_EN];
assign inv     = ctrl_q[riscboy_periph_pkg::PWM_CTRL_INV];

// ==============================
// APB registers
// ==============================

always_comb begin
	rdata = '0;
	err   = 1'b0;
	case (reg_sel)
		riscboy_periph_pkg::PWM_CTRL: rdata = riscboy_periph_pkg::word_t'(ctrl_q);
		riscboy_periph_pkg::PWM_DIV:  rdata = riscboy_periph_pkg::word_t'(div_q);
		riscboy_periph_pkg::PWM_CMP:  rdata = riscboy_periph_pkg::word_t'(cmp_q);
		default:                      err = 1'b1;
	endcase
end

assign o_apb.prdata  = rdata;
assign o_apb.pslverr = i_apb.psel && err;
assign wr_en         = i_apb.psel && i_apb.penable && i_apb.pwrite && !err;

always_ff @(posedge i_clk_sys or negedge i_rst_n) begin
	if (!i_rst_n) begin
		ctrl_q <= '0;
		div_q  <= '0;
		cmp_q  <= '0;
	end else if (wr_en) begin
		case (reg_sel)
			riscboy_periph_pkg::PWM_CTRL:
				ctrl_q <= i_apb.pwdata[riscboy_periph_pkg::W_PWM_CTRL-1:0];
			riscboy_periph_pkg::PWM_DIV:  div_q <= i_apb.pwdata[riscboy_periph_pkg::W_PWM-1:0];
			riscboy_periph_pkg::PWM_CMP:  cmp_q <= i_apb.pwdata[riscboy_periph_pkg::W_PWM-1:0];
			default: ;
		endcase
	end
end

// ==============================
// Divider and duty counter
// ==============================

// Compare with >= so a smaller DIV written mid-count takes effect at once
assign tick = div_ctr >= div_q;

// Free running, so register writes never restart the period
always_ff @(posedge i_clk_sys or negedge i_rst_n) begin
	if (!i_rst_n) begin
		div_ctr <= '0;
		ctr     <= '0;
	end else if (tick) begin
		div_ctr <= '0;
		ctr     <= ctr + riscboy_periph_pkg::pwm_t'(1);  // Wraps at 256
	end else begin
		div_ctr <= div_ctr + riscboy_periph_pkg::pwm_t'(1);
	end
end

always_ff @(posedge i_clk_sys or negedge i_rst_n) begin
	if (!i_rst_n)
		pwm_q <= 1'b0;
	else if (en)
		pwm_q <= (ctr < cmp_q) ^ inv;
	else
		pwm_q <= inv;                // Idle level follows invert
end

assign o_lcd_pwm = pwm_q;

// One cycle of slack after a DIV write, then the divider is back in range
a_div_ctr_in_range: assert property (
	@(posedge i_clk_sys) disable iff (!i_rst_n)
	!$changed(div_q) |-> div_ctr <= div_q
);

endmodule

// File: src/riscboy_periph.sv
// Peripheral subsystem top: APB splitter feeding the GPIO and backlight PWM blocks
module riscboy_periph (
	input  logic                         i_clk_sys,
	input  logic                         i_rst_n,

	// APB port from the external requester
	input  riscboy_periph_pkg::apb_req_t i_apb,
	output riscboy_periph_pkg::apb_rsp_t o_apb,

	// Pads
	output riscboy_periph_pkg::pad_t     o_padout,
	output riscboy_periph_pkg::pad_t     o_padoe,
	input  riscboy_periph_pkg::pad_t     i_padin,

	output logic                         o_lcd_pwm   // LCD backlight
);

// ==============================
// Interconnect
// ==============================

riscboy_periph_pkg::apb_req_t gpio_req;
riscboy_periph_pkg::apb_rsp_t gpio_rsp;
riscboy_periph_pkg::apb_req_t pwm_req;
riscboy_periph_pkg::apb_rsp_t pwm_rsp;

// ==============================
// Bus fabric
// ==============================

apb_splitter u_splitter (
	.i_clk_sys  (i_clk_sys),
	.i_rst_n    (i_rst_n),
	.i_apb      (i_apb),
	.o_apb      (o_apb),
	.o_gpio_req (gpio_req),
	.i_gpio_rsp (gpio_rsp),
	.o_pwm_req  (pwm_req),
	.i_pwm_rsp  (pwm_rsp)
);

// ==============================
// Peripherals
// ==============================

gpio u_gpio (
	.i_clk_sys (i_clk_sys),
	.i_rst_n   (i_rst_n),
	.i_apb     (gpio_req),   // Region 0x0
	.o_apb     (gpio_rsp),
	.o_padout  (o_padout),
	.o_padoe   (o_padoe),
	.i_padin   (i_padin)
);

pwm_tiny u_pwm (
	.i_clk_sys (i_clk_sys),
	.i_rst_n   (i_rst_n),
	.i_apb     (pwm_req),    // Region 0x1
	.o_apb     (pwm_rsp),
	.o_lcd_pwm (o_lcd_pwm)
);

endmodule

// File: src/riscboy_periph_pkg.sv
// Shared widths, address map, register offsets and APB structs, referenced by scoped names
package riscboy_periph_pkg;

// ==============================
// Widths
// ==============================

localparam int W_PADDR    = 16;                  // APB address
localparam int W_DATA     = 32;                  // APB data
localparam int N_PADS     = 11;
localparam int W_PWM      = 8;                   // PWM counter, compare and divider
localparam int W_OFFSET   = 12;                  // Register offset inside one block
localparam int W_REGION   = W_PADDR - W_OFFSET;  // Region select bits above the offset
localparam int W_PWM_CTRL = 2;

// PWM_CTRL bit positions
localparam int PWM_CTRL_EN  = 0;
localparam int PWM_CTRL_INV = 1;

// ==============================
// Address map
// ==============================

localparam logic [W_REGION-1:0] REGION_GPIO = 4'h0;
localparam logic [W_REGION-1:0] REGION_PWM  = 4'h1;

// ==============================
// Types
// ==============================

typedef logic [W_PADDR-1:0] paddr_t;
typedef logic [W_DATA-1:0]  word_t;
typedef logic [N_PADS-1:0]  pad_t;
typedef logic [W_PWM-1:0]   pwm_t;

// Slot the splitter routes an access to
typedef enum logic [1:0] {
	SLOT_GPIO = 2'd0,
	SLOT_PWM  = 2'd1,
	SLOT_NONE = 2'd3     // Unmapped, answered by the splitter
} apb_slot_e;

typedef enum logic [W_OFFSET-1:0] {
	GPIO_OUT = 12'h000,
	GPIO_OE  = 12'h004,
	GPIO_IN  = 12'h008   // Read only
} gpio_reg_e;

typedef enum logic [W_OFFSET-1:0] {
	PWM_CTRL = 12'h000,  // Bit 0 enable, bit 1 invert
	PWM_DIV  = 12'h004,
	PWM_CMP  = 12'h008
} pwm_reg_e;

// APB request from requester to completer
typedef struct packed {
	paddr_t paddr;
	logic   psel;
	logic   penable;
	logic   pwrite;
	word_t  pwdata;
} apb_req_t;

// APB response, no pready since every access completes in its access phase
typedef struct packed {
	word_t prdata;
	logic  pslverr;
} apb_rsp_t;

endpackage

// File: tb.f
src/riscboy_periph_pkg.sv
src/apb_splitter.sv
src/gpio.sv
src/pwm_tiny.sv
src/riscboy_periph.sv
dv/tb_clkgen.sv
dv/tb_riscboy_periph.sv
